// File: common/taylor_pkg.sv
package taylor_pkg;

    // ------------------------------
    // Widths and fixed-point format
    // ------------------------------

    // Sample and coefficient width, signed Q2.16
    localparam int DATA_W = 18;

    // Accumulator and product width of the datapath
    localparam int ACC_W = 48;

    // Fractional bits of a sample
    localparam int FRAC_W = 16;

    // Terms after the constant, also the top power-table index
    localparam int TERMS = 10;

    // Width of the term indices
    localparam int IDX_W = 4;

    // Operand cycle to product valid
    localparam int MAC_LAT = 3;

    // One in Q2.16
    localparam logic signed [DATA_W-1:0] ONE_Q = 18'sh10000;

    // ------------------------------
    // Enumerations
    // ------------------------------

    // Selectable functions
    typedef enum logic [2:0] {
        FUNC_COS  = 3'd0,
        FUNC_SIN  = 3'd1,
        FUNC_EXP  = 3'd2,
        FUNC_COSH = 3'd3,
        FUNC_SINH = 3'd4
    } taylor_func_e;

    // Datapath operations
    typedef enum logic [1:0] {
        // Product held at zero
        MAC_NOP  = 2'd0,
        // A times B
        MAC_MUL  = 2'd1,
        // A times B plus C
        MAC_MADD = 2'd2
    } mac_op_e;

    // ------------------------------
    // Helpers
    // ------------------------------

    // Truncate a datapath product back to a Q2.16 sample
    function automatic logic signed [DATA_W-1:0] acc_to_q(
        input logic signed [ACC_W-1:0] p
    );
        return p[FRAC_W+DATA_W-1:FRAC_W];
    endfunction

endpackage

// File: compile.f
common/taylor_pkg.sv
logic/dsp_mac.sv
taylor/taylor_coefs.sv
taylor/taylor_calc.sv
logic/taylor_unit.sv
dv/taylor_unit_tb.sv

// File: dv/taylor_unit_tb.sv
`timescale 1ns/10ps

module taylor_unit_tb
    import taylor_pkg::*;
();

    localparam logic [31:0] RAND_SEED   = 32'h23cf5a8e;
    localparam int          RESET_CYC   = 16;
    localparam int          REQ_CNT     = 95;
    localparam int          TIMEOUT_CYC = 60 * REQ_CNT + RESET_CYC + 8;
    // Series tolerance, truncation adds one LSB per term
    localparam int          TOL_LSB     = 16 + TERMS;
    // Input ranges in LSB, 1.5 and 0.6
    localparam int          WIDE_LIM    = 98304;
    localparam int          NARROW_LIM  = 39321;
    localparam real         Q_SCALE     = 65536.0;

    // Clock on reset, reset on clk
    logic                     reset;
    logic                     clk;
    logic                     calc;
    taylor_func_e             func;
    logic signed [DATA_W-1:0] xl_in;
    logic signed [DATA_W-1:0] xr_in;
    logic                     done;
    logic signed [DATA_W-1:0] resl;
    logic signed [DATA_W-1:0] resr;

    // Outstanding requests, oldest first
    string                    name_q [$];
    taylor_func_e             func_q [$];
    logic signed [DATA_W-1:0] exp_xl_q [$];
    logic signed [DATA_W-1:0] exp_xr_q [$];
    int                       strobe_q [$];

    int cycle       = 0;
    int issue_count = 0;
    int done_count  = 0;
    int ref_latency = 0;

    taylor_unit taylor_unit_inst (
        .i_reset (reset),
        .i_clk   (clk),
        .i_calc  (calc),
        .i_func  (func),
        .i_xl    (xl_in),
        .i_xr    (xr_in),
        .o_done  (done),
        .o_resl  (resl),
        .o_resr  (resr)
    );

    always #10 reset = ~reset;

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic report_mismatch(input string test, input string expected, input string actual);
        $display("Mismatch in %s: expected %s, actual %s", test, expected, actual);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(posedge reset) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC) begin
            report_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYC));
        end
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    // n-th derivative at zero
    function automatic int deriv_sign(input taylor_func_e f, input int n);
        case (f)
            FUNC_COS:  return (n % 4 == 0) ? 1 : ((n % 4 == 2) ? -1 : 0);
            FUNC_SIN:  return (n % 4 == 1) ? 1 : ((n % 4 == 3) ? -1 : 0);
            FUNC_EXP:  return 1;
            FUNC_COSH: return (n % 2 == 0) ? 1 : 0;
            FUNC_SINH: return (n % 2 == 1) ? 1 : 0;
            default:   return 0;
        endcase
    endfunction

    function automatic real series_model(input taylor_func_e f,
                                         input logic signed [DATA_W-1:0] x_q);
        real x;
        real term;
        real sum;
        int  x_i;
        x_i  = x_q;
        x    = x_i / Q_SCALE;
        term = 1.0;
        sum  = 0.0;
        for (int n = 0; n <= TERMS; n++) begin
            sum  = sum + deriv_sign(f, n) * term;
            term = term * x / (n + 1);
        end
        return sum;
    endfunction

    function automatic logic signed [DATA_W-1:0] rand_sample(input int limit);
        int v;
        v = int'($urandom_range(2 * limit, 0)) - limit;
        return v[DATA_W-1:0];
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_idle(input string name);
        assert (!done) else report_error($sformatf("o_done high during %s", name));
        assert (resl == '0 && resr == '0)
            else report_mismatch(name, "0/0", $sformatf("%0d/%0d", resl, resr));
    endtask

    task automatic check_lane(input string name, input string lane, input taylor_func_e f,
                              input logic signed [DATA_W-1:0] x,
                              input logic signed [DATA_W-1:0] act);
        string test;
        real   expected;
        real   diff;
        int    act_i;
        int    exact;
        test     = $sformatf("%s %s %s lane", name, f.name(), lane);
        act_i    = act;
        expected = series_model(f, x) * Q_SCALE;
        diff     = act_i - expected;
        if (diff < 0.0) begin
            diff = -diff;
        end
        assert (diff <= TOL_LSB)
            else report_mismatch(test, $sformatf("%0.1f", expected), $sformatf("%0d", act_i));
        // Zero input leaves only the constant term
        if (x == '0) begin
            exact = deriv_sign(f, 0) * 65536;
            assert (act_i == exact)
                else report_mismatch(test, $sformatf("%0d", exact), $sformatf("%0d", act_i));
        end
    endtask

    // Never two done cycles in a row
    assert property (@(posedge reset) disable iff (clk) !(done && $past(done)))
        else report_error("o_done held high for more than one cycle");

    assert property (@(posedge reset) disable iff (clk) done || (resl == '0 && resr == '0))
        else report_mismatch("idle_results", "0/0", $sformatf("%0d/%0d", resl, resr));

    always @(negedge reset) begin : done_monitor
        string                    name;
        taylor_func_e             f;
        logic signed [DATA_W-1:0] xl;
        logic signed [DATA_W-1:0] xr;
        int                       lat;
        if (done) begin
            if (name_q.size() == 0) begin
                report_error("o_done pulsed with no request pending");
            end else begin
                name = name_q.pop_front();
                f    = func_q.pop_front();
                xl   = exp_xl_q.pop_front();
                xr   = exp_xr_q.pop_front();
                lat  = cycle - strobe_q.pop_front();
                if (ref_latency == 0) begin
                    ref_latency = lat;
                end
                assert (lat == ref_latency)
                    else report_mismatch($sformatf("%s latency", name),
                                         $sformatf("%0d", ref_latency), $sformatf("%0d", lat));
                check_lane(name, "left", f, xl, resl);
                check_lane(name, "right", f, xr, resr);
                done_count++;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Called on a rising edge, returns on the next one
    task automatic issue_request(input string name, input taylor_func_e f,
                                 input logic signed [DATA_W-1:0] xl,
                                 input logic signed [DATA_W-1:0] xr);
        calc  <= 1'b1;
        func  <= f;
        xl_in <= xl;
        xr_in <= xr;
        name_q.push_back(name);
        func_q.push_back(f);
        exp_xl_q.push_back(xl);
        exp_xr_q.push_back(xr);
        // Count as it reads after this edge
        strobe_q.push_back(cycle + 1);
        issue_count++;
        @(posedge reset);
        calc <= 1'b0;
    endtask

    task automatic wait_done();
        while (done_count != issue_count) begin
            @(posedge reset);
        end
    endtask

    initial begin : stimulus
        taylor_func_e f;
        reset = 1'b0;
        clk   = 1'b1;
        calc  = 1'b0;
        func  = FUNC_COS;
        xl_in = '0;
        xr_in = '0;
        void'($urandom(RAND_SEED));

        repeat (RESET_CYC) begin
            @(negedge reset);
            check_idle("reset");
        end
        @(posedge reset);
        clk <= 1'b0;
        repeat (4) begin
            @(negedge reset);
            check_idle("after_reset");
        end
        @(posedge reset);

        // Circular functions over the wide range
        for (int k = 0; k < 40; k++) begin
            f = (k % 2 == 0) ? FUNC_COS : FUNC_SIN;
            issue_request("cos_sin_random", f, rand_sample(WIDE_LIM), rand_sample(WIDE_LIM));
            wait_done();
            repeat ($urandom_range(2, 0)) @(posedge reset);
        end

        // Exponential family over the narrow range
        for (int k = 0; k < 40; k++) begin
            case (k % 3)
                0:       f = FUNC_EXP;
                1:       f = FUNC_COSH;
                default: f = FUNC_SINH;
            endcase
            issue_request("exp_hyp_random", f, rand_sample(NARROW_LIM), rand_sample(NARROW_LIM));
            wait_done();
            repeat ($urandom_range(2, 0)) @(posedge reset);
        end

        for (int k = 0; k < 5; k++) begin
            issue_request("zero_input", taylor_func_e'(k), '0, '0);
            wait_done();
            @(posedge reset);
        end

        // Each new strobe lands on the previous o_done cycle
        issue_request("back_to_back", FUNC_EXP, rand_sample(NARROW_LIM), rand_sample(NARROW_LIM));
        for (int k = 0; k < 5; k++) begin
            repeat (ref_latency - 1) @(posedge reset);
            f = (k % 2 == 0) ? FUNC_SINH : FUNC_COS;
            issue_request("back_to_back", f, rand_sample(NARROW_LIM), rand_sample(NARROW_LIM));
            assert (done_count == issue_count - 1)
                else report_error("previous request not done on the chained strobe cycle");
        end
        wait_done();
        @(posedge reset);

        // Strobes while busy carry other inputs
        for (int k = 0; k < 4; k++) begin
            issue_request("busy_strobe", FUNC_COS, rand_sample(WIDE_LIM), rand_sample(WIDE_LIM));
            repeat (6) @(posedge reset);
            repeat (3) begin
                calc  <= 1'b1;
                func  <= FUNC_EXP;
                xl_in <= rand_sample(WIDE_LIM);
                xr_in <= rand_sample(WIDE_LIM);
                @(posedge reset);
                calc <= 1'b0;
                repeat (8) @(posedge reset);
            end
            wait_done();
            @(posedge reset);
        end

        // Quiet tail, no stray done
        repeat (ref_latency + 4) @(posedge reset);
        if (issue_count == REQ_CNT && done_count == REQ_CNT) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_error($sformatf("expected %0d completed requests, saw %0d",
                                   REQ_CNT, done_count));
        end
    end

endmodule

// File: logic/dsp_mac.sv
`timescale 1ns/10ps

module dsp_mac
    import taylor_pkg::*;
(
    input  logic                     i_reset,
    input  logic                     i_clk,
    input  mac_op_e                  i_op,
    input  logic signed [DATA_W-1:0] i_a,
    input  logic signed [DATA_W-1:0] i_b,
    input  logic signed [ACC_W-1:0]  i_c,
    output logic signed [ACC_W-1:0]  o_p
);

    mac_op_e                    op_s1;
    mac_op_e                    op_s2;
    logic signed [DATA_W-1:0]   a_s1;
    logic signed [DATA_W-1:0]   b_s1;
    logic signed [ACC_W-1:0]    c_s1;
    logic signed [ACC_W-1:0]    c_s2;
    logic signed [2*DATA_W-1:0] prod_s2;
    logic signed [ACC_W-1:0]    prod_ext;
    logic signed [ACC_W-1:0]    addend;

    // Opcode pipeline
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            op_s1 <= MAC_NOP;
            op_s2 <= MAC_NOP;
        end else begin
            op_s1 <= i_op;
            op_s2 <= op_s1;
        end
    end

    // Operands, then product
    always_ff @(posedge i_reset) begin
        a_s1    <= i_a;
        b_s1    <= i_b;
        c_s1    <= i_c;
        prod_s2 <= a_s1 * b_s1;
        c_s2    <= c_s1;
    end

    assign prod_ext = prod_s2;
    assign addend   = (op_s2 == MAC_MADD) ? c_s2 : '0;

    // Sum stage
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            o_p <= '0;
        end else if (op_s2 == MAC_NOP) begin
            o_p <= '0;
        end else begin
            o_p <= prod_ext + addend;
        end
    end

endmodule

// File: logic/taylor_unit.sv
`timescale 1ns/10ps

module taylor_unit
    import taylor_pkg::*;
(
    input  logic                     i_reset,
    input  logic                     i_clk,
    input  logic                     i_calc,
    input  taylor_func_e             i_func,
    input  logic signed [DATA_W-1:0] i_xl,
    input  logic signed [DATA_W-1:0] i_xr,
    output logic                     o_done,
    output logic signed [DATA_W-1:0] o_resl,
    output logic signed [DATA_W-1:0] o_resr
);

    taylor_func_e             coef_func;
    logic [IDX_W-1:0]         coef_idx;
    logic signed [DATA_W-1:0] coef;
    mac_op_e                  mac_op;
    logic signed [DATA_W-1:0] mac_al;
    logic signed [DATA_W-1:0] mac_bl;
    logic signed [ACC_W-1:0]  mac_cl;
    logic signed [ACC_W-1:0]  mac_pl;
    logic signed [DATA_W-1:0] mac_ar;
    logic signed [DATA_W-1:0] mac_br;
    logic signed [ACC_W-1:0]  mac_cr;
    logic signed [ACC_W-1:0]  mac_pr;

    taylor_calc taylor_calc_inst (
        .i_reset     (i_reset),
        .i_clk       (i_clk),
        .i_calc      (i_calc),
        .i_func      (i_func),
        .i_xl        (i_xl),
        .i_xr        (i_xr),
        .o_done      (o_done),
        .o_resl      (o_resl),
        .o_resr      (o_resr),
        .o_coef_func (coef_func),
        .o_coef_idx  (coef_idx),
        .i_coef      (coef),
        .o_mac_op    (mac_op),
        .o_mac_al    (mac_al),
        .o_mac_bl    (mac_bl),
        .o_mac_cl    (mac_cl),
        .i_mac_pl    (mac_pl),
        .o_mac_ar    (mac_ar),
        .o_mac_br    (mac_br),
        .o_mac_cr    (mac_cr),
        .i_mac_pr    (mac_pr)
    );

    taylor_coefs taylor_coefs_inst (
        .i_func (coef_func),
        .i_idx  (coef_idx),
        .o_coef (coef)
    );

    // Left lane
    dsp_mac dsp_mac_l (
        .i_reset (i_reset),
        .i_clk   (i_clk),
        .i_op    (mac_op),
        .i_a     (mac_al),
        .i_b     (mac_bl),
        .i_c     (mac_cl),
        .o_p     (mac_pl)
    );

    // Right lane
    dsp_mac dsp_mac_r (
        .i_reset (i_reset),
        .i_clk   (i_clk),
        .i_op    (mac_op),
        .i_a     (mac_ar),
        .i_b     (mac_br),
        .i_c     (mac_cr),
        .o_p     (mac_pr)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the taylor_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module taylor_unit_tb \
    -f compile.f \
    -o taylor_unit_sim

# Exit status is nonzero when the testbench hits $fatal
./obj_dir/taylor_unit_sim

// File: taylor/taylor_calc.sv
`timescale 1ns/10ps

module taylor_calc
    import taylor_pkg::*;
(
    input  logic                     i_reset,
    input  logic                     i_clk,
    input  logic                     i_calc,
    input  taylor_func_e             i_func,
    input  logic signed [DATA_W-1:0] i_xl,
    input  logic signed [DATA_W-1:0] i_xr,
    output logic                     o_done,
    output logic signed [DATA_W-1:0] o_resl,
    output logic signed [DATA_W-1:0] o_resr,
    output taylor_func_e             o_coef_func,
    output logic [IDX_W-1:0]         o_coef_idx,
    input  logic signed [DATA_W-1:0] i_coef,
    output mac_op_e                  o_mac_op,
    output logic signed [DATA_W-1:0] o_mac_al,
    output logic signed [DATA_W-1:0] o_mac_bl,
    output logic signed [ACC_W-1:0]  o_mac_cl,
    input  logic signed [ACC_W-1:0]  i_mac_pl,
    output logic signed [DATA_W-1:0] o_mac_ar,
    output logic signed [DATA_W-1:0] o_mac_br,
    output logic signed [ACC_W-1:0]  o_mac_cr,
    input  logic signed [ACC_W-1:0]  i_mac_pr
);

    // Micro-tasks, several may be active in one step
    typedef struct packed {
        logic set_one;
        logic wait_in;
        logic repeat_10;
        logic clr_i;
        logic set_j;
        logic inc_i;
        logic inc_j;
        logic mul_x_fj;
        logic mul_vi_vj;
        logic mul_ac_vj;
        logic madd_vi_ci;
        logic jp_wait;
        logic jp_loop;
        logic mov_res;
    } utask_t;

    logic [3:0]                    pc;
    utask_t                        ut;
    logic [IDX_W-1:0]              idx_i;
    logic [IDX_W-1:0]              idx_j;
    logic [IDX_W-1:0]              rpt_cnt;
    logic                          rpt_last;
    logic                          start;
    taylor_func_e                  func_q;
    logic signed [DATA_W-1:0]      xl_q;
    logic signed [DATA_W-1:0]      xr_q;
    logic signed [DATA_W-1:0]      inv_j;
    logic signed [DATA_W-1:0]      acc_l;
    logic signed [DATA_W-1:0]      acc_r;
    logic                          issue_mul;
    logic [MAC_LAT-1:0]            wr_vld;
    logic [MAC_LAT-1:0][IDX_W-1:0] wr_idx;
    logic signed [DATA_W-1:0]      pow_l [0:TERMS];
    logic signed [DATA_W-1:0]      pow_r [0:TERMS];

    // ------------------------------
    // Microcode
    // ------------------------------
    always_comb begin
        ut = '0;
        case (pc)
            4'd0: ut.set_one = 1'b1;
            4'd1: begin
                ut.wait_in = 1'b1;
                ut.set_j   = 1'b1;
            end
            // x times 1/j for j = 1..10
            4'd2: begin
                ut.repeat_10 = 1'b1;
                ut.mul_x_fj  = 1'b1;
                ut.inc_j     = 1'b1;
            end
            4'd4: begin
                ut.clr_i = 1'b1;
                ut.set_j = 1'b1;
            end
            // Chain x^j/j! from the previous power
            4'd5: begin
                ut.mul_vi_vj = (idx_i == '0);
                ut.mul_ac_vj = (idx_i != '0);
            end
            4'd6: begin
                ut.madd_vi_ci = 1'b1;
                ut.inc_i      = 1'b1;
                ut.inc_j      = 1'b1;
            end
            4'd7: ut.jp_loop = (idx_j != IDX_W'(TERMS));
            // Last power, then terms nine and ten
            4'd8: ut.mul_ac_vj = 1'b1;
            4'd9: begin
                ut.madd_vi_ci = 1'b1;
                ut.inc_i      = 1'b1;
            end
            4'd12: ut.madd_vi_ci = 1'b1;
            4'd15: begin
                ut.mov_res = 1'b1;
                ut.jp_wait = 1'b1;
            end
            // Pipeline bubbles
            default: ut = '0;
        endcase
    end

    assign start    = ut.wait_in & i_calc;
    assign rpt_last = (rpt_cnt == IDX_W'(TERMS - 1));

    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            pc <= '0;
        end else if (ut.jp_wait) begin
            pc <= 4'd1;
        end else if (ut.jp_loop) begin
            pc <= 4'd5;
        end else if ((ut.wait_in && !i_calc) || (ut.repeat_10 && !rpt_last)) begin
            pc <= pc;
        end else begin
            pc <= pc + 4'd1;
        end
    end

    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            rpt_cnt <= '0;
        end else if (ut.repeat_10 && !rpt_last) begin
            rpt_cnt <= rpt_cnt + 1'b1;
        end else begin
            rpt_cnt <= '0;
        end
    end

    // Index registers
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            idx_i <= '0;
            idx_j <= '0;
        end else begin
            if (ut.clr_i) begin
                idx_i <= '0;
            end else if (ut.inc_i) begin
                idx_i <= idx_i + 1'b1;
            end
            if (ut.set_j) begin
                idx_j <= IDX_W'(1);
            end else if (ut.inc_j) begin
                idx_j <= idx_j + 1'b1;
            end
        end
    end

    // Request capture, only in the idle step
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            func_q <= FUNC_COS;
        end else if (start) begin
            func_q <= i_func;
        end
    end

    always_ff @(posedge i_reset) begin
        if (start) begin
            xl_q <= i_xl;
            xr_q <= i_xr;
        end
    end

    assign o_coef_func = func_q;
    assign o_coef_idx  = idx_i;

    // 1/j in Q2.16
    always_comb begin
        case (idx_j)
            4'd1:    inv_j = 18'sh10000;
            4'd2:    inv_j = 18'sh08000;
            4'd3:    inv_j = 18'sh05555;
            4'd4:    inv_j = 18'sh04000;
            4'd5:    inv_j = 18'sh03333;
            4'd6:    inv_j = 18'sh02aab;
            4'd7:    inv_j = 18'sh02492;
            4'd8:    inv_j = 18'sh02000;
            4'd9:    inv_j = 18'sh01c72;
            4'd10:   inv_j = 18'sh0199a;
            default: inv_j = '0;
        endcase
    end

    // ------------------------------
    // Datapath operands
    // ------------------------------
    assign acc_l = acc_to_q(i_mac_pl);
    assign acc_r = acc_to_q(i_mac_pr);

    always_comb begin
        o_mac_op = MAC_NOP;
        o_mac_al = '0;
        o_mac_bl = '0;
        o_mac_cl = '0;
        o_mac_ar = '0;
        o_mac_br = '0;
        o_mac_cr = '0;
        if (ut.mul_x_fj) begin
            o_mac_op = MAC_MUL;
            o_mac_al = xl_q;
            o_mac_ar = xr_q;
            o_mac_bl = inv_j;
            o_mac_br = inv_j;
        end else if (ut.mul_vi_vj) begin
            o_mac_op = MAC_MUL;
            o_mac_al = pow_l[idx_i];
            o_mac_ar = pow_r[idx_i];
            o_mac_bl = pow_l[idx_j];
            o_mac_br = pow_r[idx_j];
        end else if (ut.mul_ac_vj) begin
            o_mac_op = MAC_MUL;
            o_mac_al = acc_l;
            o_mac_ar = acc_r;
            o_mac_bl = pow_l[idx_j];
            o_mac_br = pow_r[idx_j];
        end else if (ut.madd_vi_ci) begin
            // Running sum rides on the previous result
            o_mac_op = MAC_MADD;
            o_mac_al = pow_l[idx_i];
            o_mac_ar = pow_r[idx_i];
            o_mac_bl = i_coef;
            o_mac_br = i_coef;
            o_mac_cl = i_mac_pl;
            o_mac_cr = i_mac_pr;
        end
    end

    // ------------------------------
    // Power table write-back
    // ------------------------------
    assign issue_mul = ut.mul_x_fj | ut.mul_vi_vj | ut.mul_ac_vj;

    // Index travels alongside the product
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            wr_vld <= '0;
            wr_idx <= '0;
        end else begin
            wr_vld <= {wr_vld[MAC_LAT-2:0], issue_mul};
            wr_idx <= {wr_idx[MAC_LAT-2:0], idx_j};
        end
    end

    always_ff @(posedge i_reset) begin
        if (ut.set_one) begin
            pow_l[0] <= ONE_Q;
            pow_r[0] <= ONE_Q;
        end else if (wr_vld[MAC_LAT-1]) begin
            pow_l[wr_idx[MAC_LAT-1]] <= acc_l;
            pow_r[wr_idx[MAC_LAT-1]] <= acc_r;
        end
    end

    // Results, zero outside the done pulse
    always_ff @(posedge i_reset or posedge i_clk) begin
        if (i_clk) begin
            o_done <= 1'b0;
            o_resl <= '0;
            o_resr <= '0;
        end else if (ut.mov_res) begin
            o_done <= 1'b1;
            o_resl <= acc_l;
            o_resr <= acc_r;
        end else begin
            o_done <= 1'b0;
            o_resl <= '0;
            o_resr <= '0;
        end
    end

endmodule

// File: taylor/taylor_coefs.sv
`timescale 1ns/10ps

module taylor_coefs
    import taylor_pkg::*;
(
    input  taylor_func_e             i_func,
    input  logic [IDX_W-1:0]         i_idx,
    output logic signed [DATA_W-1:0] o_coef
);

    logic signed [DATA_W-1:0] minus_one;
    logic                     odd;
    logic                     neg;

    assign minus_one = -ONE_Q;

    // Derivative patterns repeat every four terms
    assign odd = i_idx[0];
    assign neg = i_idx[1];

    always_comb begin
        case (i_func)
            // 1, 0, -1, 0
            FUNC_COS:  o_coef = odd ? '0 : (neg ? minus_one : ONE_Q);
            // 0, 1, 0, -1
            FUNC_SIN:  o_coef = !odd ? '0 : (neg ? minus_one : ONE_Q);
            FUNC_EXP:  o_coef = ONE_Q;
            // Even terms only
            FUNC_COSH: o_coef = odd ? '0 : ONE_Q;
            // Odd terms only
            FUNC_SINH: o_coef = odd ? ONE_Q : '0;
            default:   o_coef = '0;
        endcase
    end

endmodule
